// ==== src/vit_pkg.sv ====
`default_nettype none

package vit_pkg;

    localparam int FRAME_W   = 276;
    localparam int DECODED_W = 138; // one bit per trellis step at rate 1/2
    localparam int METRIC_W  = 10;
    localparam int STEP_W    = 7;

    localparam logic CODE_RATE_2 = 1'b0;
    localparam logic CODE_RATE_3 = 1'b1;

    localparam int STEPS_R2 = 69; // cycles per frame, two steps each
    localparam int STEPS_R3 = 46;

    // generators act on the register {input, state[1], state[0]}
    localparam logic [2:0] G0     = 3'b111;
    localparam logic [2:0] G1 [2] = '{3'b101, 3'b111}; // indexed by code rate
    localparam logic [2:0] G2     = 3'b101;            // rate 1/3 only

    typedef logic [FRAME_W-1:0]   frame_t;
    typedef logic [2:0]           sym_t;
    typedef logic [1:0]           bm_t;
    typedef bm_t  [15:0]          bm_set_t; // entry 8*step + register
    typedef logic [METRIC_W-1:0]  metric_t;
    typedef logic [STEP_W-1:0]    step_t;
    typedef logic [7:0]           surv_t;   // 2-bit predecessor per state
    typedef logic [DECODED_W-1:0] decoded_t;

    typedef enum logic [1:0] {CS_IDLE, CS_FWD, CS_TRACE, CS_DONE} ctrl_state_e;

    // code word for one trellis step, bit 2 stays zero at rate 1/2
    function automatic sym_t code_word(input logic rate, input logic [2:0] regv);
        sym_t cw;
        cw[0] = ^(G0 & regv);
        cw[1] = ^(G1[rate] & regv);
        cw[2] = (rate == CODE_RATE_3) ? ^(G2 & regv) : 1'b0;
        return cw;
    endfunction

endpackage

`default_nettype wire

// ==== src/vit_ifs.sv ====
`default_nettype none

// symbol pairs from the slicer into the forward path
interface slice_if;
    vit_pkg::sym_t sym_a;  // earlier step of the pair
    vit_pkg::sym_t sym_b;
    logic          valid;
    logic          last;   // final pair of the frame

    modport source (output sym_a, sym_b, valid, last);
    modport sink   (input  sym_a, sym_b, valid, last);
endinterface

// survivor words from the ACS into the traceback memory
interface surv_if;
    logic                we;
    vit_pkg::step_t      addr;
    vit_pkg::surv_t      bits;
    logic                last;

    modport source (output we, addr, bits, last);
    modport sink   (input  we, addr, bits, last);
endinterface

`default_nettype wire

// ==== src/frame_slicer.sv ====
`default_nettype none

module frame_slicer (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            i_start,
    input  wire vit_pkg::frame_t i_frame,
    input  wire logic            i_code_rate,
    input  wire logic            i_en,
    input  wire vit_pkg::step_t  i_index,
    input  wire logic            i_last,
    slice_if.source              o_sym
);

    vit_pkg::frame_t frame_q;
    logic            rate_q;
    logic [8:0]      base;  // frame bit of the first code bit of the pair

    // two symbols per cycle, so 4 or 6 bits per index
    assign base = (rate_q == vit_pkg::CODE_RATE_3) ? 9'(i_index) * 9'd6
                                                   : {i_index, 2'b00};

    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            frame_q <= i_frame;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rate_q <= vit_pkg::CODE_RATE_2;
        end
        else if (i_start)
        begin
            rate_q <= i_code_rate;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_en)
        begin
            if (rate_q == vit_pkg::CODE_RATE_3)
            begin
                o_sym.sym_a <= frame_q[base +: 3];
                o_sym.sym_b <= frame_q[base + 9'd3 +: 3];
            end
            else
            begin
                o_sym.sym_a <= {1'b0, frame_q[base +: 2]};
                o_sym.sym_b <= {1'b0, frame_q[base + 9'd2 +: 2]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            o_sym.valid <= 1'b0;
            o_sym.last  <= 1'b0;
        end
        else
        begin
            o_sym.valid <= i_en;
            o_sym.last  <= i_en & i_last;
        end
    end

endmodule

`default_nettype wire

// ==== src/step_counter.sv ====
`default_nettype none

module step_counter (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           i_code_rate,
    input  wire logic           i_load,
    input  wire logic           i_en,
    input  wire logic           i_dir,   // 1 counts down
    output vit_pkg::step_t      o_index,
    output logic                o_last
);

    vit_pkg::step_t end_val;
    logic           dir_q;

    assign end_val = (i_code_rate == vit_pkg::CODE_RATE_3)
                   ? vit_pkg::step_t'(vit_pkg::STEPS_R3 - 1)
                   : vit_pkg::step_t'(vit_pkg::STEPS_R2 - 1);

    assign o_last = dir_q ? (o_index == '0) : (o_index == end_val);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            o_index <= '0;
            dir_q   <= 1'b0;
        end
        else if (i_load)
        begin
            o_index <= i_dir ? end_val : '0;
            dir_q   <= i_dir;
        end
        else if (i_en)
        begin
            o_index <= dir_q ? o_index - 1'b1 : o_index + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/decode_ctrl.sv ====
`default_nettype none

module decode_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic i_start,
    input  wire logic i_cnt_last,
    input  wire logic i_surv_done,  // final survivor write
    output logic      o_load,
    output logic      o_en,
    output logic      o_dir,
    output logic      o_fwd,
    output logic      o_trace,
    output logic      o_clear,
    output logic      o_busy,
    output logic      o_done
);

    vit_pkg::ctrl_state_e state, state_nxt;
    logic fed;  // every pair already handed to the slicer

    assign o_clear = (state == vit_pkg::CS_IDLE) & i_start;
    assign o_fwd   = (state == vit_pkg::CS_FWD) & ~fed;
    assign o_trace = (state == vit_pkg::CS_TRACE);
    assign o_en    = o_fwd | o_trace;
    assign o_dir   = (state == vit_pkg::CS_FWD);  // reload for traceback counts down
    assign o_load  = o_clear | ((state == vit_pkg::CS_FWD) & i_surv_done);
    assign o_busy  = (state != vit_pkg::CS_IDLE);
    assign o_done  = (state == vit_pkg::CS_DONE);

    always_comb
    begin
        state_nxt = state;
        case (state)
            vit_pkg::CS_IDLE:  if (i_start)     state_nxt = vit_pkg::CS_FWD;
            vit_pkg::CS_FWD:   if (i_surv_done) state_nxt = vit_pkg::CS_TRACE;
            vit_pkg::CS_TRACE: if (i_cnt_last)  state_nxt = vit_pkg::CS_DONE;
            default:                            state_nxt = vit_pkg::CS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= vit_pkg::CS_IDLE;
            fed   <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (o_clear)
                fed <= 1'b0;
            else if (o_fwd & i_cnt_last)
                fed <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/branch_metric.sv ====
`default_nettype none

module branch_metric (
    input  wire logic       i_code_rate,
    slice_if.sink           i_sym,
    output vit_pkg::bm_set_t o_bm
);

    logic [2:0] mask;

    // bit 2 carries nothing at rate 1/2
    assign mask = (i_code_rate == vit_pkg::CODE_RATE_3) ? 3'b111 : 3'b011;

    always_comb
    begin : hamming
        vit_pkg::sym_t cw;
        logic [2:0]    diff_a;
        logic [2:0]    diff_b;
        for (int r = 0; r < 8; r++)
        begin
            cw     = vit_pkg::code_word(i_code_rate, 3'(r));
            diff_a = (i_sym.sym_a ^ cw) & mask;
            diff_b = (i_sym.sym_b ^ cw) & mask;
            o_bm[r]     = vit_pkg::bm_t'(diff_a[0]) + vit_pkg::bm_t'(diff_a[1])
                        + vit_pkg::bm_t'(diff_a[2]);
            o_bm[8 + r] = vit_pkg::bm_t'(diff_b[0]) + vit_pkg::bm_t'(diff_b[1])
                        + vit_pkg::bm_t'(diff_b[2]);
        end
    end

endmodule

`default_nettype wire

// ==== src/acs_radix4.sv ====
`default_nettype none

module acs_radix4 (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             i_clear,
    input  wire vit_pkg::bm_set_t i_bm,
    slice_if.sink                 i_sym,
    surv_if.source                o_surv
);

    localparam int SUM_W = vit_pkg::METRIC_W + 1;

    vit_pkg::metric_t pm [4];
    logic [SUM_W-1:0] best [4];
    logic [1:0]       pick [4];   // winning predecessor per new state
    vit_pkg::step_t   wr_addr;

    // new state s = {u2, u1}, every old state p reaches it in two steps
    always_comb
    begin : acs
        logic [1:0]       sv;
        logic [1:0]       pv;
        logic [SUM_W-1:0] cand;
        for (int s = 0; s < 4; s++)
        begin
            sv      = 2'(s);
            best[s] = '1;
            pick[s] = 2'd0;
            for (int p = 0; p < 4; p++)
            begin
                pv   = 2'(p);
                cand = SUM_W'(pm[p]) + SUM_W'(i_bm[{1'b0, sv[0], pv}])
                     + SUM_W'(i_bm[{1'b1, sv, pv[1]}]);
                if (cand < best[s])  // strict, lowest p wins a tie
                begin
                    best[s] = cand;
                    pick[s] = pv;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int s = 0; s < 4; s++)
                pm[s] <= (s == 0) ? '0 : '1;
            wr_addr     <= '0;
            o_surv.we   <= 1'b0;
            o_surv.last <= 1'b0;
        end
        else
        begin
            if (i_clear)
            begin
                for (int s = 0; s < 4; s++)
                    pm[s] <= (s == 0) ? '0 : '1;  // only state 0 is a valid start
                wr_addr <= '0;
            end
            else if (i_sym.valid)
            begin
                for (int s = 0; s < 4; s++)
                    pm[s] <= best[s][vit_pkg::METRIC_W-1:0];
                wr_addr <= wr_addr + 1'b1;
            end
            o_surv.we   <= i_sym.valid;
            o_surv.last <= i_sym.valid & i_sym.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_sym.valid)
        begin
            o_surv.addr <= wr_addr;
            o_surv.bits <= {pick[3], pick[2], pick[1], pick[0]};
        end
    end

endmodule

`default_nettype wire

// ==== src/traceback_unit.sv ====
`default_nettype none

module traceback_unit (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           i_clear,
    input  wire logic           i_en,
    input  wire vit_pkg::step_t i_index,
    surv_if.sink                i_surv,
    output vit_pkg::decoded_t   o_data
);

    vit_pkg::surv_t mem [vit_pkg::STEPS_R2];  // one word per forward cycle
    vit_pkg::surv_t word;
    logic [1:0]     state;                     // walk state, {u2, u1}
    logic [1:0]     pred;

    assign word = mem[i_index];
    assign pred = word[{state, 1'b0} +: 2];

    always_ff @(posedge clk)
    begin
        if (i_surv.we)
        begin
            mem[i_surv.addr] <= i_surv.bits;
        end
    end

    // tail bits force the frame to end in state 0
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= 2'd0;
        end
        else if (i_surv.we & i_surv.last)
        begin
            state <= 2'd0;
        end
        else if (i_en)
        begin
            state <= pred;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            o_data <= '0;
        end
        else if (i_clear)
        begin
            o_data <= '0;
        end
        else if (i_en)
        begin
            o_data[{i_index, 1'b0}] <= state[0];  // earlier step of the pair
            o_data[{i_index, 1'b1}] <= state[1];
        end
    end

endmodule

`default_nettype wire

// ==== src/viterbi_top.sv ====
`default_nettype none

module viterbi_top (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            i_start,
    input  wire logic            i_code_rate,
    input  wire vit_pkg::frame_t i_frame,
    output logic                 o_busy,
    output logic                 o_done,
    output vit_pkg::decoded_t    o_data
);

    logic             cnt_load;
    logic             cnt_en;
    logic             cnt_dir;
    logic             cnt_last;
    vit_pkg::step_t   cnt_index;
    logic             fwd;
    logic             trace;
    logic             clear;   // accepted start
    vit_pkg::bm_set_t bm;

    slice_if sym_bus ();
    surv_if  surv_bus ();

    decode_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_cnt_last  (cnt_last),
        .i_surv_done (surv_bus.last),  // last is only high with we
        .o_load      (cnt_load),
        .o_en        (cnt_en),
        .o_dir       (cnt_dir),
        .o_fwd       (fwd),
        .o_trace     (trace),
        .o_clear     (clear),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    step_counter u_cnt (
        .clk         (clk),
        .rst         (rst),
        .i_code_rate (i_code_rate),
        .i_load      (cnt_load),
        .i_en        (cnt_en),
        .i_dir       (cnt_dir),
        .o_index     (cnt_index),
        .o_last      (cnt_last)
    );

    frame_slicer u_slicer (
        .clk         (clk),
        .rst         (rst),
        .i_start     (clear),
        .i_frame     (i_frame),
        .i_code_rate (i_code_rate),
        .i_en        (fwd),
        .i_index     (cnt_index),
        .i_last      (cnt_last),
        .o_sym       (sym_bus.source)
    );

    branch_metric u_bm (
        .i_code_rate (i_code_rate),
        .i_sym       (sym_bus.sink),
        .o_bm        (bm)
    );

    acs_radix4 u_acs (
        .clk     (clk),
        .rst     (rst),
        .i_clear (clear),
        .i_bm    (bm),
        .i_sym   (sym_bus.sink),
        .o_surv  (surv_bus.source)
    );

    traceback_unit u_tb (
        .clk     (clk),
        .rst     (rst),
        .i_clear (clear),
        .i_en    (trace),
        .i_index (cnt_index),
        .i_surv  (surv_bus.sink),
        .o_data  (o_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_viterbi.sv ====
`default_nettype none

module tb_viterbi;

    localparam int DONE_TIMEOUT = 400;
    localparam int NUM_TESTS    = 12;

    localparam logic [1:0] MODE_RAND = 2'd0;
    localparam logic [1:0] MODE_ZERO = 2'd1;
    localparam logic [1:0] MODE_ALT  = 2'd2;
    localparam logic [1:0] MODE_ONES = 2'd3;

    // err holds frame bit indices with entry 0 in the low bits
    typedef struct packed {
        logic            rate;
        logic [1:0]      mode;
        logic            twice;  // second start while busy
        logic [2:0]      n_err;
        logic [7:0]      n_msg;  // expected message bits in o_data
        logic [3:0][8:0] err;
    } test_row_t;

    test_row_t tests [NUM_TESTS] = '{
        '{vit_pkg::CODE_RATE_2, MODE_RAND, 1'b0, 3'd0, 8'd136, 36'd0},
        '{vit_pkg::CODE_RATE_2, MODE_ZERO, 1'b0, 3'd0, 8'd136, 36'd0},
        '{vit_pkg::CODE_RATE_2, MODE_ALT,  1'b0, 3'd0, 8'd136, 36'd0},
        '{vit_pkg::CODE_RATE_2, MODE_ONES, 1'b0, 3'd0, 8'd136, 36'd0},
        '{vit_pkg::CODE_RATE_3, MODE_RAND, 1'b0, 3'd0, 8'd90,  36'd0},
        '{vit_pkg::CODE_RATE_3, MODE_ALT,  1'b0, 3'd0, 8'd90,  36'd0},
        '{vit_pkg::CODE_RATE_3, MODE_ONES, 1'b0, 3'd0, 8'd90,  36'd0},
        '{vit_pkg::CODE_RATE_2, MODE_RAND, 1'b0, 3'd4, 8'd136, {9'd240, 9'd160, 9'd80, 9'd10}},
        '{vit_pkg::CODE_RATE_3, MODE_RAND, 1'b0, 3'd4, 8'd90,  {9'd250, 9'd170, 9'd90, 9'd9}},
        '{vit_pkg::CODE_RATE_2, MODE_RAND, 1'b1, 3'd1, 8'd136, {27'd0, 9'd100}},
        '{vit_pkg::CODE_RATE_3, MODE_ZERO, 1'b0, 3'd2, 8'd90,  {18'd0, 9'd200, 9'd30}},
        '{vit_pkg::CODE_RATE_2, MODE_ONES, 1'b0, 3'd2, 8'd136, {18'd0, 9'd230, 9'd50}}
    };

    logic              clk;
    logic              rst;
    logic              i_start;
    logic              i_code_rate;
    vit_pkg::frame_t   i_frame;
    logic              o_busy;
    logic              o_done;
    vit_pkg::decoded_t o_data;

    integer seed;
    int     test_errs;
    int     pass_count;
    int     fail_count;
    int     done_count = 0;
    logic   aborted;

    viterbi_top dut (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_code_rate (i_code_rate),
        .i_frame     (i_frame),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_data      (o_data)
    );

    always #10 clk = ~clk;

    // counted away from the rising edge
    always @(negedge clk)
    begin
        if (o_done === 1'b1)
            done_count++;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_value(input string name, input logic [137:0] got,
                                input logic [137:0] exp);
        $display("Error: time %0t %s got %0h expected %0h", $time, name, got, exp);
        test_errs++;
    endtask

    // message bits above n_msg stay zero including the tail
    function automatic vit_pkg::decoded_t build_message(input logic [1:0] mode,
                                                        input int n_msg);
        vit_pkg::decoded_t m;
        int                r;
        m = '0;
        for (int k = 0; k < n_msg; k++)
        begin
            case (mode)
                MODE_RAND:
                begin
                    r    = $random(seed);
                    m[k] = r[0];
                end
                MODE_ALT:  m[k] = ~k[0];  // 1010...
                MODE_ONES: m[k] = 1'b1;
                default:   m[k] = 1'b0;
            endcase
        end
        return m;
    endfunction

    // reference encoder with register {input, state}
    function automatic vit_pkg::frame_t encode_frame(input logic rate,
                                                     input vit_pkg::decoded_t msg);
        vit_pkg::frame_t f;
        logic [1:0]      st;
        logic [2:0]      regv;
        logic [2:0]      g1;
        int              n;
        n  = (rate == vit_pkg::CODE_RATE_3) ? 3 : 2;
        g1 = (rate == vit_pkg::CODE_RATE_3) ? vit_pkg::G1[1] : vit_pkg::G1[0];
        f  = '0;
        st = 2'b00;
        for (int k = 0; k < vit_pkg::FRAME_W / n; k++)
        begin
            regv       = {msg[k], st};
            f[n*k]     = ^(vit_pkg::G0 & regv);
            f[n*k + 1] = ^(g1 & regv);
            if (n == 3)
                f[n*k + 2] = ^(vit_pkg::G2 & regv);
            st = regv[2:1];  // newest input moves into state bit 1
        end
        return f;
    endfunction

    task automatic run_row(input int t);
        test_row_t         row;
        vit_pkg::decoded_t msg;
        vit_pkg::frame_t   frame;
        int                cycles;
        int                done_base;
        logic              busy_drop;
        row       = tests[t];
        test_errs = 0;
        busy_drop = 1'b0;
        msg       = build_message(row.mode, int'(row.n_msg));
        frame     = encode_frame(row.rate, msg);
        for (int e = 0; e < row.n_err; e++)
            frame[row.err[e]] = ~frame[row.err[e]];
        done_base   = done_count;
        i_code_rate = row.rate;  // held until the next row
        i_frame     = frame;
        i_start     = 1'b1;
        next_cycle();
        i_start = 1'b0;
        if (o_busy !== 1'b1)
            report_value("o_busy", o_busy, 1'b1);
        cycles = 0;
        while (o_done !== 1'b1 && cycles < DONE_TIMEOUT)
        begin
            if (o_busy !== 1'b1 && !busy_drop)
            begin
                report_value("o_busy", o_busy, 1'b1);
                busy_drop = 1'b1;  // one report per frame
            end
            i_start = row.twice && (cycles == 5);  // must be ignored
            if (i_start)
                i_frame = ~frame;
            next_cycle();
            cycles++;
        end
        i_start = 1'b0;
        if (o_done !== 1'b1)
        begin
            $display("test %0d: timeout, o_done did not rise within %0d cycles",
                     t, DONE_TIMEOUT);
            aborted = 1'b1;
        end
        else
        begin
            if (o_data !== msg)
                report_value("o_data", o_data, msg);
            next_cycle();
            if (o_done !== 1'b0)
                report_value("o_done", o_done, 1'b0);
            if (o_busy !== 1'b0)
                report_value("o_busy", o_busy, 1'b0);
            if (row.twice)
            begin
                repeat (DONE_TIMEOUT) next_cycle();  // long enough for a queued frame
                if (done_count - done_base != 1)
                    report_value("o_done pulses", done_count - done_base, 1);
            end
            $display("test %0d rate 1/%0d mode %0d errors %0d double start %0d: %s",
                     t, (row.rate == vit_pkg::CODE_RATE_3) ? 3 : 2, row.mode,
                     row.n_err, row.twice, (test_errs == 0) ? "ok" : "FAILED");
        end
    endtask

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b0;
        i_start     = 1'b0;
        i_code_rate = vit_pkg::CODE_RATE_2;
        i_frame     = '0;
        seed        = 32'h5ef9;
        pass_count  = 0;
        fail_count  = 0;
        aborted     = 1'b0;
        test_errs   = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;

        // idle outputs straight after reset
        if (o_busy !== 1'b0)
            report_value("o_busy", o_busy, 1'b0);
        if (o_done !== 1'b0)
            report_value("o_done", o_done, 1'b0);
        if (o_data !== '0)
            report_value("o_data", o_data, '0);
        $display("reset state: %s", (test_errs == 0) ? "ok" : "FAILED");
        if (test_errs == 0)
            pass_count++;
        else
            fail_count++;
        next_cycle();

        for (int t = 0; t < NUM_TESTS && !aborted; t++)
        begin
            run_row(t);
            if (test_errs == 0 && !aborted)
                pass_count++;
            else
                fail_count++;
        end

        $display("checks run %0d, passed %0d, failed %0d", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0 && !aborted)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/vit_pkg.sv
src/vit_ifs.sv
src/frame_slicer.sv
src/step_counter.sv
src/decode_ctrl.sv
src/branch_metric.sv
src/acs_radix4.sv
src/traceback_unit.sv
src/viterbi_top.sv
tb/tb_viterbi.sv

// ==== Bender.yml ====
package:
  name: viterbi_decoder

sources:
  - src/vit_pkg.sv
  - src/vit_ifs.sv
  - src/frame_slicer.sv
  - src/step_counter.sv
  - src/decode_ctrl.sv
  - src/branch_metric.sv
  - src/acs_radix4.sv
  - src/traceback_unit.sv
  - src/viterbi_top.sv
  - target: test
    files:
      - tb/tb_viterbi.sv
